// File: Makefile
# Verilator build and regression run for the CSR unit

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard logic/*.sv include/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: csr_unit.f
+incdir+include
logic/csr_pkg.sv
logic/csr_if.sv
logic/csr_access_decode.sv
logic/csr_machine_regs.sv
logic/csr_read_stage.sv
logic/csr_unit.sv
testbench/csr_unit_tb.sv

// File: include/csr_defines.svh
// Widths, CSR addresses, writable masks and reset values
// for the machine-mode CSR unit
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Datapath widths
`define CSR_XLEN        32
`define CSR_COUNTER_W   64
`define CSR_ADDR_W      12
`define CSR_ECODE_W     4

// Identification constants
`define CSR_HART_ID     32'h0000_0000
`define CSR_MISA_VALUE  32'h4000_0100

// Machine trap setup and handling
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MHARTID    12'hF14

// Counters, machine copies and user read-only aliases
`define CSR_ADDR_MCYCLE     12'hB00
`define CSR_ADDR_MINSTRET   12'hB02
`define CSR_ADDR_MCYCLEH    12'hB80
`define CSR_ADDR_MINSTRETH  12'hB82
`define CSR_ADDR_CYCLE      12'hC00
`define CSR_ADDR_INSTRET    12'hC02
`define CSR_ADDR_CYCLEH     12'hC80
`define CSR_ADDR_INSTRETH   12'hC82

// mie, mpie and mpp
`define CSR_MSTATUS_WMASK   32'h0000_1888
`define CSR_RESET_PRIV      2'b11

`endif

// File: logic/csr_access_decode.sv
// CSR address decode, privilege check and write value computation
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_access_decode
    import csr_pkg::*;
(
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  csr_op_e                csr_op,
    input  logic [`CSR_XLEN-1:0]   rs1,
    input  logic                   new_request,
    input  logic                   commit,
    input  priv_e                  priv,
    input  logic [`CSR_XLEN-1:0]   read_q,
    output logic                   illegal,
    output csr_sel_e               sel,
    csr_write_if.decoder           wr
);

    logic priv_fail;
    logic read_only;
    logic access_ok;

    always_comb begin
        case (csr_addr)
            `CSR_ADDR_MSTATUS:   sel = csr_sel_mstatus;
            `CSR_ADDR_MISA:      sel = csr_sel_misa;
            `CSR_ADDR_MTVEC:     sel = csr_sel_mtvec;
            `CSR_ADDR_MSCRATCH:  sel = csr_sel_mscratch;
            `CSR_ADDR_MEPC:      sel = csr_sel_mepc;
            `CSR_ADDR_MCAUSE:    sel = csr_sel_mcause;
            `CSR_ADDR_MHARTID:   sel = csr_sel_mhartid;
            `CSR_ADDR_MCYCLE:    sel = csr_sel_mcycle;
            `CSR_ADDR_MCYCLEH:   sel = csr_sel_mcycleh;
            `CSR_ADDR_MINSTRET:  sel = csr_sel_minstret;
            `CSR_ADDR_MINSTRETH: sel = csr_sel_minstreth;
            `CSR_ADDR_CYCLE:     sel = csr_sel_cycle;
            `CSR_ADDR_CYCLEH:    sel = csr_sel_cycleh;
            `CSR_ADDR_INSTRET:   sel = csr_sel_instret;
            `CSR_ADDR_INSTRETH:  sel = csr_sel_instreth;
            default:             sel = csr_sel_none;
        endcase
    end

    // Address bits 9:8 hold the lowest privilege allowed
    assign priv_fail = csr_addr[9:8] > priv;
    assign read_only = csr_addr[11:10] == 2'b11;
    assign access_ok = (sel != csr_sel_none) && !priv_fail;

    assign illegal = new_request && !access_ok;

    ////////////////////
    // Write request
    always_comb begin
        case (csr_op)
            csr_op_rw: wr.wdata = rs1;
            csr_op_rs: wr.wdata = read_q | rs1;
            csr_op_rc: wr.wdata = read_q & ~rs1;
            default:   wr.wdata = rs1;
        endcase
    end

    assign wr.sel      = sel;
    assign wr.write_en = commit && access_ok && !read_only;

endmodule

// File: logic/csr_if.sv
// Write request bus from the decoder and register state bus to the read stage
`timescale 1ns/100ps
`include "csr_defines.svh"

interface csr_write_if
    import csr_pkg::*;
();
    csr_sel_e                sel;
    logic                    write_en;
    logic [`CSR_XLEN-1:0]    wdata;

    modport decoder (output sel, output write_en, output wdata);
    modport store (input sel, input write_en, input wdata);
endinterface

interface csr_state_if
    import csr_pkg::*;
();
    mstatus_t                 mstatus;
    logic [`CSR_XLEN-1:0]     mtvec;
    logic [`CSR_XLEN-1:0]     mepc;
    logic [`CSR_XLEN-1:0]     mcause;
    logic [`CSR_XLEN-1:0]     mscratch;
    logic [`CSR_COUNTER_W-1:0] mcycle;
    logic [`CSR_COUNTER_W-1:0] minstret;

    modport store (
        output mstatus, output mtvec, output mepc, output mcause,
        output mscratch, output mcycle, output minstret
    );
    modport reader (
        input mstatus, input mtvec, input mepc, input mcause,
        input mscratch, input mcycle, input minstret
    );
endinterface

// File: logic/csr_machine_regs.sv
// Privilege level, trap entry and return, machine registers
// and the cycle and instret counters
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_machine_regs
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    csr_write_if.store              wr,
    input  logic                    exception_valid,
    input  logic [`CSR_ECODE_W-1:0] exception_code,
    input  logic [`CSR_XLEN-1:0]    exception_pc,
    input  logic                    mret,
    input  logic                    instruction_complete,
    csr_state_if.store              st,
    output priv_e                   priv,
    output logic [`CSR_XLEN-1:0]    trap_pc,
    output logic [`CSR_XLEN-1:0]    mepc_out
);

    mstatus_t                  mstatus;
    mstatus_t                  mstatus_next;
    priv_e                     priv_next;
    logic [`CSR_XLEN-1:0]      mtvec;
    logic [`CSR_XLEN-1:0]      mepc;
    logic [`CSR_XLEN-1:0]      mcause;
    logic [`CSR_XLEN-1:0]      mscratch;
    logic [`CSR_COUNTER_W-1:0] mcycle;
    logic [`CSR_COUNTER_W-1:0] minstret;
    logic                      instret_inc;

    function automatic logic hit(csr_sel_e target);
        return wr.write_en && (wr.sel == target);
    endfunction

    ////////////////////
    // Privilege and mstatus
    always_comb begin
        priv_next    = priv;
        mstatus_next = mstatus;
        if (exception_valid) begin
            mstatus_next.mpie = mstatus.mie;
            mstatus_next.mie  = 1'b0;
            mstatus_next.mpp  = priv;
            priv_next         = priv_machine;
        end else if (mret) begin
            // Only user and machine exist, so anything else returns to user
            priv_next = (mstatus.mpp == priv_machine) ? priv_machine : priv_user;
            mstatus_next.mie  = mstatus.mpie;
            mstatus_next.mpie = 1'b1;
            mstatus_next.mpp  = priv_user;
        end else if (hit(csr_sel_mstatus)) begin
            mstatus_next = mstatus_t'(wr.wdata & `CSR_MSTATUS_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv        <= priv_e'(`CSR_RESET_PRIV);
            mstatus     <= '0;
            mstatus.mpp <= `CSR_RESET_PRIV;
        end else begin
            priv    <= priv_next;
            mstatus <= mstatus_next;
        end
    end

    ////////////////////
    // Trap registers
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else begin
            if (hit(csr_sel_mtvec))
                mtvec <= {wr.wdata[`CSR_XLEN-1:2], 2'b00};
            if (hit(csr_sel_mscratch))
                mscratch <= wr.wdata;
            // Trap entry wins over software writes
            if (exception_valid) begin
                mepc   <= {exception_pc[`CSR_XLEN-1:2], 2'b00};
                mcause <= {{(`CSR_XLEN-`CSR_ECODE_W){1'b0}}, exception_code};
            end else begin
                if (hit(csr_sel_mepc))
                    mepc <= {wr.wdata[`CSR_XLEN-1:2], 2'b00};
                if (hit(csr_sel_mcause))
                    mcause <= wr.wdata;
            end
        end
    end

    ////////////////////
    // Counters
    always_ff @(posedge clk) begin
        if (rst) begin
            instret_inc <= 1'b0;
            mcycle      <= '0;
            minstret    <= '0;
        end else begin
            instret_inc <= instruction_complete;

            if (hit(csr_sel_mcycle))
                mcycle <= {mcycle[`CSR_COUNTER_W-1:`CSR_XLEN], wr.wdata};
            else if (hit(csr_sel_mcycleh))
                mcycle <= {wr.wdata, mcycle[`CSR_XLEN-1:0]};
            else
                mcycle <= mcycle + 1'b1;

            if (hit(csr_sel_minstret))
                minstret <= {minstret[`CSR_COUNTER_W-1:`CSR_XLEN], wr.wdata};
            else if (hit(csr_sel_minstreth))
                minstret <= {wr.wdata, minstret[`CSR_XLEN-1:0]};
            else
                minstret <= minstret + `CSR_COUNTER_W'(instret_inc);
        end
    end

    assign st.mstatus  = mstatus;
    assign st.mtvec    = mtvec;
    assign st.mepc     = mepc;
    assign st.mcause   = mcause;
    assign st.mscratch = mscratch;
    assign st.mcycle   = mcycle;
    assign st.minstret = minstret;

    // Vector mode is fixed to direct
    assign trap_pc  = mtvec;
    assign mepc_out = mepc;

endmodule

// File: logic/csr_pkg.sv
// Opcode, privilege and CSR selector enums plus the mstatus layout
package csr_pkg;

    // Access operation, low bits of funct3
    typedef enum logic [1:0] {
        csr_op_rw = 2'b01,
        csr_op_rs = 2'b10,
        csr_op_rc = 2'b11
    } csr_op_e;

    // Same encoding as address bits 9:8
    typedef enum logic [1:0] {
        priv_user    = 2'b00,
        priv_machine = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        csr_sel_none,
        csr_sel_mstatus,
        csr_sel_misa,
        csr_sel_mtvec,
        csr_sel_mscratch,
        csr_sel_mepc,
        csr_sel_mcause,
        csr_sel_mhartid,
        csr_sel_mcycle,
        csr_sel_mcycleh,
        csr_sel_minstret,
        csr_sel_minstreth,
        csr_sel_cycle,
        csr_sel_cycleh,
        csr_sel_instret,
        csr_sel_instreth
    } csr_sel_e;

    // Only the machine interrupt stack is implemented
    typedef struct packed {
        logic [18:0] zero_hi;
        logic [1:0]  mpp;
        logic [2:0]  zero_mid;
        logic        mpie;
        logic [2:0]  zero_lo2;
        logic        mie;
        logic [2:0]  zero_lo;
    } mstatus_t;

endpackage

// File: logic/csr_read_stage.sv
// CSR read mux and the registered read result
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_read_stage
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  read_regs,
    input  csr_sel_e              sel,
    csr_state_if.reader           st,
    output logic [`CSR_XLEN-1:0]  read_q
);

    logic [`CSR_XLEN-1:0] selected;

    always_comb begin
        case (sel)
            csr_sel_mstatus:  selected = st.mstatus;
            csr_sel_misa:     selected = `CSR_MISA_VALUE;
            csr_sel_mtvec:    selected = st.mtvec;
            csr_sel_mscratch: selected = st.mscratch;
            csr_sel_mepc:     selected = st.mepc;
            csr_sel_mcause:   selected = st.mcause;
            csr_sel_mhartid:  selected = `CSR_HART_ID;
            // User aliases read the same counters
            csr_sel_mcycle,
            csr_sel_cycle:    selected = st.mcycle[`CSR_XLEN-1:0];
            csr_sel_mcycleh,
            csr_sel_cycleh:   selected = st.mcycle[`CSR_COUNTER_W-1:`CSR_XLEN];
            csr_sel_minstret,
            csr_sel_instret:  selected = st.minstret[`CSR_XLEN-1:0];
            csr_sel_minstreth,
            csr_sel_instreth: selected = st.minstret[`CSR_COUNTER_W-1:`CSR_XLEN];
            default:          selected = '0;
        endcase
    end

    // Result is zero in any cycle not following read_regs
    always_ff @(posedge clk) begin
        if (rst)
            read_q <= '0;
        else if (read_regs)
            read_q <= selected;
        else
            read_q <= '0;
    end

endmodule

// File: logic/csr_unit.sv
// Top level of the CSR unit: decoder, register store and read stage
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_unit
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    // Request
    input  logic                    new_request,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  csr_op_e                 csr_op,
    input  logic [`CSR_XLEN-1:0]    rs1,
    input  logic                    read_regs,
    input  logic                    commit,
    // Traps
    input  logic                    exception_valid,
    input  logic [`CSR_ECODE_W-1:0] exception_code,
    input  logic [`CSR_XLEN-1:0]    exception_pc,
    input  logic                    mret,
    input  logic                    instruction_complete,
    // Results
    output logic                    csr_exception,
    output logic [`CSR_XLEN-1:0]    wb_csr,
    output logic [`CSR_XLEN-1:0]    trap_pc,
    output logic [`CSR_XLEN-1:0]    csr_mepc,
    output priv_e                   current_privilege
);

    csr_sel_e             sel;
    logic [`CSR_XLEN-1:0] read_q;

    csr_write_if wr_if ();
    csr_state_if st_if ();

    csr_access_decode decode_i (
        .csr_addr    (csr_addr),
        .csr_op      (csr_op),
        .rs1         (rs1),
        .new_request (new_request),
        .commit      (commit),
        .priv        (current_privilege),
        .read_q      (read_q),
        .illegal     (csr_exception),
        .sel         (sel),
        .wr          (wr_if.decoder)
    );

    csr_machine_regs regs_i (
        .clk                  (clk),
        .rst                  (rst),
        .wr                   (wr_if.store),
        .exception_valid      (exception_valid),
        .exception_code       (exception_code),
        .exception_pc         (exception_pc),
        .mret                 (mret),
        .instruction_complete (instruction_complete),
        .st                   (st_if.store),
        .priv                 (current_privilege),
        .trap_pc              (trap_pc),
        .mepc_out             (csr_mepc)
    );

    csr_read_stage read_i (
        .clk       (clk),
        .rst       (rst),
        .read_regs (read_regs),
        .sel       (sel),
        .st        (st_if.reader),
        .read_q    (read_q)
    );

    assign wb_csr = read_q;

endmodule

// File: testbench/csr_unit_tb.sv
// Testbench for the CSR unit with clock, reset, LFSR stimulus,
// reference model of the machine registers and assertion checks
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_unit_tb
    import csr_pkg::*;
();

    localparam int CLK_HALF      = 50;
    localparam int DRIVE_DELAY   = 10;
    localparam int PRIV_TIMEOUT  = 4;

    logic                    clk;
    logic                    rst;
    logic                    new_request;
    logic [`CSR_ADDR_W-1:0]  csr_addr;
    csr_op_e                 csr_op;
    logic [`CSR_XLEN-1:0]    rs1;
    logic                    read_regs;
    logic                    commit;
    logic                    exception_valid;
    logic [`CSR_ECODE_W-1:0] exception_code;
    logic [`CSR_XLEN-1:0]    exception_pc;
    logic                    mret;
    logic                    instruction_complete;
    logic                    csr_exception;
    logic [`CSR_XLEN-1:0]    wb_csr;
    logic [`CSR_XLEN-1:0]    trap_pc;
    logic [`CSR_XLEN-1:0]    csr_mepc;
    priv_e                   current_privilege;

    // Reference model
    mstatus_t             m_mstatus;
    logic [`CSR_XLEN-1:0] m_mtvec;
    logic [`CSR_XLEN-1:0] m_mepc;
    logic [`CSR_XLEN-1:0] m_mcause;
    logic [`CSR_XLEN-1:0] m_mscratch;
    priv_e                m_priv;

    // Expectations for the current request and their registered copies
    logic [`CSR_XLEN-1:0] exp_val;
    logic                 exp_known;
    logic                 exp_exc;
    logic [`CSR_XLEN-1:0] exp_q;
    logic                 known_q;
    logic                 zero_q;

    logic [31:0] lfsr_state;
    int          errors;
    int          tests_run;
    int          tests_failed;

    csr_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////
    // Checks
    always @(posedge clk) begin
        exp_q   <= exp_val;
        known_q <= read_regs && exp_known;
        zero_q  <= !read_regs;
    end

    // Sampled at the falling edge away from drives and updates
    read_value_check: assert property (@(negedge clk) disable iff (rst)
        known_q |-> wb_csr == exp_q)
        else begin
            errors++;
            $display("mismatch at %0t: wb_csr expected %h, got %h", $time, exp_q, wb_csr);
        end

    idle_zero_check: assert property (@(negedge clk) disable iff (rst)
        zero_q |-> wb_csr == '0)
        else begin
            errors++;
            $display("mismatch at %0t: wb_csr expected 0, got %h", $time, wb_csr);
        end

    exception_check: assert property (@(negedge clk) disable iff (rst)
        csr_exception == (new_request && exp_exc))
        else begin
            errors++;
            $display("mismatch at %0t: csr_exception expected %b, got %b",
                     $time, new_request && exp_exc, csr_exception);
        end

    privilege_check: assert property (@(negedge clk) disable iff (rst)
        current_privilege == m_priv)
        else begin
            errors++;
            $display("mismatch at %0t: current_privilege expected %0d, got %0d",
                     $time, m_priv, current_privilege);
        end

    trap_pc_check: assert property (@(negedge clk) disable iff (rst)
        trap_pc == m_mtvec && csr_mepc == m_mepc)
        else begin
            errors++;
            $display("mismatch at %0t: trap_pc/csr_mepc expected %h/%h, got %h/%h",
                     $time, m_mtvec, m_mepc, trap_pc, csr_mepc);
        end

    ////////////////////
    // Helpers
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] result;
        logic        feedback;
        int          i;
        result = '0;
        for (i = 0; i < count; i++) begin
            // Taps 32, 22, 2, 1
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            result     = {result[30:0], feedback};
        end
        return result;
    endfunction

    function automatic logic addr_legal(input logic [`CSR_ADDR_W-1:0] addr);
        logic known;
        case (addr)
            `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
            `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MHARTID,
            `CSR_ADDR_MCYCLE, `CSR_ADDR_MINSTRET, `CSR_ADDR_MCYCLEH, `CSR_ADDR_MINSTRETH,
            `CSR_ADDR_CYCLE, `CSR_ADDR_INSTRET, `CSR_ADDR_CYCLEH,
            `CSR_ADDR_INSTRETH: known = 1'b1;
            default:            known = 1'b0;
        endcase
        return known && (addr[9:8] <= m_priv);
    endfunction

    // Counters and unknown addresses have no model value
    task automatic model_value(input logic [`CSR_ADDR_W-1:0] addr, output logic known,
                               output logic [`CSR_XLEN-1:0] value);
        known = 1'b1;
        case (addr)
            `CSR_ADDR_MSTATUS:  value = m_mstatus;
            `CSR_ADDR_MISA:     value = `CSR_MISA_VALUE;
            `CSR_ADDR_MTVEC:    value = m_mtvec;
            `CSR_ADDR_MSCRATCH: value = m_mscratch;
            `CSR_ADDR_MEPC:     value = m_mepc;
            `CSR_ADDR_MCAUSE:   value = m_mcause;
            `CSR_ADDR_MHARTID:  value = `CSR_HART_ID;
            default: begin
                known = 1'b0;
                value = '0;
            end
        endcase
    endtask

    task automatic model_write(input logic [`CSR_ADDR_W-1:0] addr,
                               input logic [`CSR_XLEN-1:0] value);
        case (addr)
            `CSR_ADDR_MSTATUS:  m_mstatus  = mstatus_t'(value & `CSR_MSTATUS_WMASK);
            `CSR_ADDR_MTVEC:    m_mtvec    = {value[`CSR_XLEN-1:2], 2'b00};
            `CSR_ADDR_MEPC:     m_mepc     = {value[`CSR_XLEN-1:2], 2'b00};
            `CSR_ADDR_MCAUSE:   m_mcause   = value;
            `CSR_ADDR_MSCRATCH: m_mscratch = value;
            default: ;
        endcase
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_privilege(input priv_e level);
        int cycles;
        cycles = 0;
        while (current_privilege != level && cycles < PRIV_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (current_privilege != level) begin
            $display("timeout: privilege level never became %0d", level);
            $display("Regression failed");
            $finish;
        end
    endtask

    ////////////////////
    // Bus operations
    task automatic read_csr(input logic [`CSR_ADDR_W-1:0] addr,
                            output logic [`CSR_XLEN-1:0] value);
        logic                 known;
        logic [`CSR_XLEN-1:0] expected;
        model_value(addr, known, expected);
        exp_exc     = !addr_legal(addr);
        exp_known   = known && !exp_exc;
        exp_val     = expected;
        new_request = 1'b1;
        csr_addr    = addr;
        read_regs   = 1'b1;
        next_cycle();
        new_request = 1'b0;
        read_regs   = 1'b0;
        exp_known   = 1'b0;
        @(negedge clk);
        value = wb_csr;
        next_cycle();
    endtask

    // Read phase then commit one cycle later since set and clear use the old value
    task automatic access_csr(input logic [`CSR_ADDR_W-1:0] addr, input csr_op_e op,
                              input logic [`CSR_XLEN-1:0] data);
        logic                 legal;
        logic                 known;
        logic [`CSR_XLEN-1:0] old;
        logic [`CSR_XLEN-1:0] result;
        legal = addr_legal(addr);
        model_value(addr, known, old);
        exp_exc     = !legal;
        exp_known   = known && legal;
        exp_val     = old;
        new_request = 1'b1;
        csr_addr    = addr;
        csr_op      = op;
        rs1         = data;
        read_regs   = 1'b1;
        next_cycle();
        read_regs = 1'b0;
        exp_known = 1'b0;
        commit    = 1'b1;
        next_cycle();
        commit      = 1'b0;
        new_request = 1'b0;
        case (op)
            csr_op_rs: result = old | data;
            csr_op_rc: result = old & ~data;
            default:   result = data;
        endcase
        if (legal) begin
            model_write(addr, result);
        end
    endtask

    task automatic take_trap(input logic [`CSR_ECODE_W-1:0] code,
                             input logic [`CSR_XLEN-1:0] pc);
        exception_valid = 1'b1;
        exception_code  = code;
        exception_pc    = pc;
        next_cycle();
        exception_valid = 1'b0;
        m_mepc          = {pc[`CSR_XLEN-1:2], 2'b00};
        m_mcause        = {{(`CSR_XLEN-`CSR_ECODE_W){1'b0}}, code};
        m_mstatus.mpie  = m_mstatus.mie;
        m_mstatus.mie   = 1'b0;
        m_mstatus.mpp   = m_priv;
        m_priv          = priv_machine;
        wait_privilege(priv_machine);
    endtask

    task automatic return_from_trap();
        mret = 1'b1;
        next_cycle();
        mret           = 1'b0;
        m_priv         = (m_mstatus.mpp == 2'b11) ? priv_machine : priv_user;
        m_mstatus.mie  = m_mstatus.mpie;
        m_mstatus.mpie = 1'b1;
        m_mstatus.mpp  = 2'b00;
        wait_privilege(m_priv);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    ////////////////////
    // Tests
    task automatic reset_state_test();
        int                   start;
        logic [`CSR_XLEN-1:0] value;
        start = errors;
        repeat (3) next_cycle();
        read_csr(`CSR_ADDR_MSTATUS, value);
        read_csr(`CSR_ADDR_MTVEC, value);
        read_csr(`CSR_ADDR_MEPC, value);
        read_csr(`CSR_ADDR_MCAUSE, value);
        read_csr(`CSR_ADDR_MSCRATCH, value);
        finish_test("reset state", start);
    endtask

    task automatic read_write_test();
        int                     start;
        logic [`CSR_XLEN-1:0]   value;
        logic [`CSR_ADDR_W-1:0] regs [4];
        csr_op_e                ops [3];
        start = errors;
        regs  = '{`CSR_ADDR_MSCRATCH, `CSR_ADDR_MTVEC, `CSR_ADDR_MEPC, `CSR_ADDR_MSTATUS};
        ops   = '{csr_op_rw, csr_op_rs, csr_op_rc};
        foreach (regs[r]) begin
            foreach (ops[o]) begin
                access_csr(regs[r], ops[o], take_bits(32));
                read_csr(regs[r], value);
            end
        end
        // Constants ignore writes
        access_csr(`CSR_ADDR_MISA, csr_op_rw, take_bits(32));
        read_csr(`CSR_ADDR_MISA, value);
        access_csr(`CSR_ADDR_MHARTID, csr_op_rs, take_bits(32));
        read_csr(`CSR_ADDR_MHARTID, value);
        finish_test("read write", start);
    endtask

    task automatic trap_return_test();
        int                   start;
        logic [`CSR_XLEN-1:0] code_bits;
        logic [`CSR_XLEN-1:0] value;
        start = errors;
        // Set mie and clear mpie so the trap moves a one into mpie
        access_csr(`CSR_ADDR_MSTATUS, csr_op_rw, 32'h0000_1808);
        code_bits = take_bits(`CSR_ECODE_W);
        take_trap(code_bits[`CSR_ECODE_W-1:0], take_bits(32));
        read_csr(`CSR_ADDR_MEPC, value);
        read_csr(`CSR_ADDR_MCAUSE, value);
        read_csr(`CSR_ADDR_MSTATUS, value);
        return_from_trap();
        read_csr(`CSR_ADDR_MSTATUS, value);
        finish_test("trap and return", start);
    endtask

    task automatic user_mode_test();
        int                   start;
        logic [`CSR_XLEN-1:0] value;
        start = errors;
        // Clear mpp so that mret drops to user
        access_csr(`CSR_ADDR_MSTATUS, csr_op_rc, 32'h0000_1800);
        return_from_trap();
        access_csr(`CSR_ADDR_MSCRATCH, csr_op_rw, take_bits(32));
        read_csr(`CSR_ADDR_CYCLE, value);
        read_csr(`CSR_ADDR_INSTRET, value);
        read_csr(12'h0FF, value);
        take_trap(4'd8, take_bits(32));
        read_csr(`CSR_ADDR_MSCRATCH, value);
        read_csr(12'h3FF, value);
        finish_test("user mode", start);
    endtask

    task automatic counters_test();
        int                   start;
        logic [31:0]          gap;
        logic [31:0]          count;
        logic [`CSR_XLEN-1:0] first;
        logic [`CSR_XLEN-1:0] second;
        logic [`CSR_XLEN-1:0] high;
        start = errors;
        gap   = 32'd2 + take_bits(4);
        read_csr(`CSR_ADDR_MCYCLE, first);
        repeat (gap - 2) next_cycle();
        read_csr(`CSR_ADDR_MCYCLE, second);
        mcycle_delta: assert (second - first == gap)
            else begin
                errors++;
                $display("mismatch at %0t: mcycle delta expected %0d, got %0d",
                         $time, gap, second - first);
            end

        count = 32'd1 + take_bits(3);
        read_csr(`CSR_ADDR_MINSTRET, first);
        repeat (count) begin
            instruction_complete = 1'b1;
            next_cycle();
            instruction_complete = 1'b0;
            next_cycle();
        end
        repeat (2) next_cycle();
        read_csr(`CSR_ADDR_MINSTRET, second);
        minstret_delta: assert (second - first == count)
            else begin
                errors++;
                $display("mismatch at %0t: minstret delta expected %0d, got %0d",
                         $time, count, second - first);
            end

        // Low half is forced close to the wrap
        high = take_bits(32);
        access_csr(`CSR_ADDR_MCYCLEH, csr_op_rw, high);
        access_csr(`CSR_ADDR_MCYCLE, csr_op_rw, 32'hFFFF_FFF8);
        repeat (12) next_cycle();
        read_csr(`CSR_ADDR_MCYCLEH, second);
        read_csr(`CSR_ADDR_MCYCLE, first);
        mcycle_wrap: assert (second == high + 32'd1 && first < 32'h40)
            else begin
                errors++;
                $display("mismatch at %0t: mcycle expected %h_000000xx, got %h_%h",
                         $time, high + 32'd1, second, first);
            end
        finish_test("counters", start);
    endtask

    ////////////////////
    // Main sequence
    initial begin
        lfsr_state           = 32'hf621_791b;
        errors               = 0;
        tests_run            = 0;
        tests_failed         = 0;
        rst                  = 1'b1;
        new_request          = 1'b0;
        csr_addr             = '0;
        csr_op               = csr_op_rw;
        rs1                  = '0;
        read_regs            = 1'b0;
        commit               = 1'b0;
        exception_valid      = 1'b0;
        exception_code       = '0;
        exception_pc         = '0;
        mret                 = 1'b0;
        instruction_complete = 1'b0;
        exp_val              = '0;
        exp_known            = 1'b0;
        exp_exc              = 1'b0;
        m_mstatus            = '0;
        m_mstatus.mpp        = 2'b11;
        m_mtvec              = '0;
        m_mepc               = '0;
        m_mcause             = '0;
        m_mscratch           = '0;
        m_priv               = priv_machine;

        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        reset_state_test();
        read_write_test();
        trap_return_test();
        user_mode_test();
        counters_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
